// ==== sched_defines.svh ====
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

`default_nettype none

// commands held in the command fifo, power of two
`define SCHED_FIFO_DEPTH 8

// clocks per time-base step
`define SCHED_TICK_DIV 4

// number of 32-bit output registers on the bus
`define SCHED_NUM_OUT 4

// a command to this address clears the time base
`define SCHED_CTRL_ADDR 16'hFFFF

`default_nettype wire

`endif

// ==== sched_pkg.sv ====
`default_nettype none

package sched_pkg;

	// one host command, stamp in the top bits
	typedef struct packed {
		logic [31:0] stamp;
		logic [15:0] addr;
		logic [31:0] data;
	} sched_cmd_t;

	// external command bus toward the devices
	typedef struct packed {
		logic [15:0] addr;
		logic [31:0] data;
		logic        en;
		logic        wr;
		// never raised, reads are not supported
		logic        rd;
	} cmd_bus_t;

endpackage

`default_nettype wire

// ==== cmd_fifo.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module cmd_fifo import sched_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  sched_cmd_t din,
	input  logic       rd_en,
	output sched_cmd_t dout,
	output logic       empty,
	output logic       full,
	output logic       valid
);

	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

	sched_cmd_t    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign empty = (count == '0);
	assign full = (count == FULL_CNT);

	// a push into a full fifo is dropped
	assign do_push = push && !full;
	assign do_pop = rd_en && !empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			valid <= 1'b0;
		end else begin
			// read data shows up one cycle after an accepted read
			valid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
		if (do_pop)
			dout <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// ==== time_base.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module time_base (
	input  logic        clk,
	input  logic        rst,
	input  logic        time_clear,
	output logic [31:0] current_time
);

	localparam int DIV = `SCHED_TICK_DIV;
	localparam int PW = (DIV > 1) ? $clog2(DIV) : 1;
	localparam int LAST_I = DIV - 1;
	localparam logic [PW-1:0] LAST = LAST_I[PW-1:0];

	logic [PW-1:0] prescale;
	logic          tick;

	// last clock of a prescale period
	assign tick = (prescale == LAST);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prescale <= '0;
			current_time <= '0;
		end else if (time_clear) begin
			// re-base the schedule
			prescale <= '0;
			current_time <= '0;
		end else if (tick) begin
			prescale <= '0;
			current_time <= current_time + 32'd1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== cmd_scheduler.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module cmd_scheduler import sched_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] current_time,
	input  sched_cmd_t  fifo_dout,
	input  logic        fifo_empty,
	input  logic        fifo_valid,
	output logic        fifo_rd_en,
	output cmd_bus_t    cmd_bus,
	output logic        time_clear
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_FIFO_WAIT = 2'd2;
	localparam logic [1:0] ST_EXEC = 2'd3;

	logic [1:0] state;
	logic [1:0] next_state;
	sched_cmd_t cmd_q;
	logic       cmd_load;
	logic       cmd_clear;
	logic       due;
	logic       is_ctrl;
	logic       fire;

	// command is due once the time base catches up with its stamp
	assign due = (current_time >= cmd_q.stamp);
	assign is_ctrl = (cmd_q.addr == `SCHED_CTRL_ADDR);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// next state and unregistered strobes
	always_comb begin
		next_state = state;
		fifo_rd_en = 1'b0;
		cmd_load = 1'b0;
		fire = 1'b0;
		case (state)
			ST_IDLE: begin
				next_state = ST_FETCH;
			end
			ST_FETCH: begin
				if (!fifo_empty) begin
					fifo_rd_en = 1'b1;
					next_state = ST_FIFO_WAIT;
				end
			end
			ST_FIFO_WAIT: begin
				// fifo data arrives on this cycle
				cmd_load = 1'b1;
				next_state = fifo_valid ? ST_EXEC : ST_FETCH;
			end
			ST_EXEC: begin
				if (due) begin
					fire = 1'b1;
					next_state = ST_FETCH;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	assign cmd_clear = fire;

	// command register, emptied once the command has fired
	always_ff @(posedge clk) begin
		if (cmd_clear)
			cmd_q <= '0;
		else if (cmd_load && fifo_valid)
			cmd_q <= fifo_dout;
	end

	// control commands clear the time base instead of writing the bus
	assign time_clear = fire && is_ctrl;

	assign cmd_bus.addr = cmd_q.addr;
	assign cmd_bus.data = cmd_q.data;
	assign cmd_bus.en = fire && !is_ctrl;
	assign cmd_bus.wr = fire && !is_ctrl;
	assign cmd_bus.rd = 1'b0;

endmodule

`default_nettype wire

// ==== out_reg_bank.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module out_reg_bank import sched_pkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  cmd_bus_t                         cmd_bus,
	output logic [`SCHED_NUM_OUT-1:0][31:0]  out_regs
);

	localparam int NUM = `SCHED_NUM_OUT;

	logic           bus_write;
	logic [NUM-1:0] sel;

	assign bus_write = cmd_bus.en && cmd_bus.wr;

	// one-hot address decode, addresses past the bank select nothing
	always_comb begin
		for (int i = 0; i < NUM; i++) begin
			sel[i] = bus_write && (cmd_bus.addr == 16'(i));
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_regs <= '0;
		end else begin
			for (int i = 0; i < NUM; i++) begin
				if (sel[i])
					out_regs[i] <= cmd_bus.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sequencer_top.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module sequencer_top import sched_pkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             cmd_push,
	input  sched_cmd_t                       cmd_in,
	output logic                             cmd_full,
	output cmd_bus_t                         cmd_bus,
	output logic [31:0]                      current_time,
	output logic [`SCHED_NUM_OUT-1:0][31:0]  out_regs
);

	sched_cmd_t fifo_dout;
	logic       fifo_empty;
	logic       fifo_valid;
	logic       fifo_rd_en;
	logic       time_clear;

	// host command queue
	cmd_fifo u_cmd_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (cmd_push),
		.din   (cmd_in),
		.rd_en (fifo_rd_en),
		.dout  (fifo_dout),
		.empty (fifo_empty),
		.full  (cmd_full),
		.valid (fifo_valid)
	);

	time_base u_time_base (
		.clk          (clk),
		.rst          (rst),
		.time_clear   (time_clear),
		.current_time (current_time)
	);

	cmd_scheduler u_cmd_scheduler (
		.clk          (clk),
		.rst          (rst),
		.current_time (current_time),
		.fifo_dout    (fifo_dout),
		.fifo_empty   (fifo_empty),
		.fifo_valid   (fifo_valid),
		.fifo_rd_en   (fifo_rd_en),
		.cmd_bus      (cmd_bus),
		.time_clear   (time_clear)
	);

	// devices on the external bus
	out_reg_bank u_out_reg_bank (
		.clk      (clk),
		.rst      (rst),
		.cmd_bus  (cmd_bus),
		.out_regs (out_regs)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== sequencer_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module sequencer_checker import sched_pkg::*; (
	input logic     clk,
	input logic     rst,
	input cmd_bus_t cmd_bus,
	input logic     time_clear,
	input logic     fifo_rd_en,
	input logic     fifo_empty
);

	// a bus strobe is always a write
	en_has_wr: assert property (@(posedge clk) disable iff (rst) cmd_bus.en |-> cmd_bus.wr)
		else $error("bus enable raised without the write flag");

	no_read: assert property (@(posedge clk) disable iff (rst) !cmd_bus.rd)
		else $error("bus read strobe raised");

	// control commands never touch the bus
	clear_or_write: assert property (@(posedge clk) disable iff (rst)
		!((cmd_bus.en || cmd_bus.wr) && time_clear))
		else $error("bus write and time clear fired together");

	write_one_cycle: assert property (@(posedge clk) disable iff (rst)
		cmd_bus.en |=> !cmd_bus.en)
		else $error("bus write strobe longer than one cycle");

	clear_one_cycle: assert property (@(posedge clk) disable iff (rst)
		time_clear |=> !time_clear)
		else $error("time clear strobe longer than one cycle");

	no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
		fifo_rd_en |-> !fifo_empty)
		else $error("fifo read requested while the fifo is empty");

endmodule

`default_nettype wire

// ==== sequencer_tb.sv ====
`timescale 1ns/10ps
`include "sched_defines.svh"
`default_nettype none

module sequencer_tb import sched_pkg::*; ();

	localparam int NUM_OUT = `SCHED_NUM_OUT;
	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	// pushes over all tests plus slack
	localparam int NUM_CMDS = DEPTH + 16;
	// largest stamp distance used by any test
	localparam int MAX_STAMP = 64;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * MAX_STAMP * `SCHED_TICK_DIV;

	logic                            clk;
	logic                            rst;
	logic                            cmd_push;
	sched_cmd_t                      cmd_in;
	logic                            cmd_full;
	cmd_bus_t                        cmd_bus;
	logic [31:0]                     current_time;
	logic [`SCHED_NUM_OUT-1:0][31:0] out_regs;

	sched_cmd_t  exp_q[$];
	logic [31:0] exp_regs [NUM_OUT];
	logic [31:0] lfsr;
	int          fire_count = 0;
	int          cycle_count = 0;
	string       test_name = "none";

	tb_clock_gen u_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	sequencer_top UUT (
		.clk          (clk),
		.rst          (rst),
		.cmd_push     (cmd_push),
		.cmd_in       (cmd_in),
		.cmd_full     (cmd_full),
		.cmd_bus      (cmd_bus),
		.current_time (current_time),
		.out_regs     (out_regs)
	);

	bind cmd_scheduler sequencer_checker u_checker (
		.clk        (clk),
		.rst        (rst),
		.cmd_bus    (cmd_bus),
		.time_clear (time_clear),
		.fifo_rd_en (fifo_rd_en),
		.fifo_empty (fifo_empty)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_val(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			fail_run($sformatf("ERR %s %s expected %h actual %h",
				test_name, what, expected, actual));
	endtask

	// galois lfsr for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic next_rand_word(output logic [31:0] word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_step(lfsr);
			word = {word[30:0], lfsr[0]};
		end
	endtask

	function automatic sched_cmd_t make_cmd(input logic [31:0] stamp,
		input logic [15:0] addr, input logic [31:0] data);
		sched_cmd_t c;
		c.stamp = stamp;
		c.addr = addr;
		c.data = data;
		return c;
	endfunction

	// earliest is the first time the command may fire in push order
	task automatic push_cmd(input sched_cmd_t c, input logic [31:0] earliest,
		output logic accepted);
		sched_cmd_t m;
		@(posedge clk);
		cmd_push <= 1'b1;
		cmd_in <= c;
		@(posedge clk);
		// full level the fifo sees on this edge
		accepted = !cmd_full;
		cmd_push <= 1'b0;
		if (accepted && c.addr != `SCHED_CTRL_ADDR) begin
			m = c;
			m.stamp = earliest;
			exp_q.push_back(m);
			if (int'(c.addr) < NUM_OUT)
				exp_regs[int'(c.addr)] = c.data;
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i < NUM_OUT; i++)
			check_val($sformatf("out_regs[%0d]", i), exp_regs[i], out_regs[i]);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		// register update lands one edge after the strobe
		repeat (2) @(posedge clk);
		check_regs();
	endtask

	// bus strobes against the model of expected writes
	always @(posedge clk) begin : strobe_monitor
		sched_cmd_t exp_cmd;
		if (!rst && (cmd_bus.en || cmd_bus.wr || cmd_bus.rd)) begin
			if (exp_q.size() == 0) begin
				fail_run($sformatf("%s: bus strobe seen with no write pending", test_name));
			end else begin
				exp_cmd = exp_q.pop_front();
				check_val("strobe en wr rd", 32'b110,
					32'({cmd_bus.en, cmd_bus.wr, cmd_bus.rd}));
				check_val("strobe addr", 32'(exp_cmd.addr), 32'(cmd_bus.addr));
				check_val("strobe data", exp_cmd.data, cmd_bus.data);
				check_val("stamp reached", 32'd1, 32'(current_time >= exp_cmd.stamp));
				fire_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	task automatic test_reset_idle();
		test_name = "reset_idle";
		@(posedge clk);
		check_val("current_time in reset", 32'd0, current_time);
		wait (rst == 1'b0);
		@(posedge clk);
		check_val("current_time after reset", 32'd0, current_time);
		for (int i = 0; i < 24; i++) begin
			check_val("bus strobes", 32'd0, 32'({cmd_bus.en, cmd_bus.wr, cmd_bus.rd}));
			check_regs();
			@(posedge clk);
		end
	endtask

	task automatic test_single_write();
		logic [31:0] d;
		logic        ok;
		int          start;
		test_name = "single_write";
		start = fire_count;
		next_rand_word(d);
		push_cmd(make_cmd(32'd0, 16'd1, d), 32'd0, ok);
		check_val("push accepted", 32'd1, 32'(ok));
		wait_drain();
		check_val("strobe count", 32'd1, fire_count - start);
	endtask

	task automatic test_ordered_writes();
		logic [31:0] d;
		logic [31:0] base;
		logic [31:0] stamp;
		logic        ok;
		test_name = "ordered_writes";
		base = current_time;
		for (int i = 0; i < 4; i++) begin
			next_rand_word(d);
			stamp = base + 32'(4 * (i + 1));
			push_cmd(make_cmd(stamp, 16'(i), d), stamp, ok);
			check_val("push accepted", 32'd1, 32'(ok));
		end
		// address outside the bank leaves the registers alone
		next_rand_word(d);
		push_cmd(make_cmd(base + 32'd20, 16'h0010, d), base + 32'd20, ok);
		next_rand_word(d);
		push_cmd(make_cmd(base + 32'd40, 16'd3, d), base + 32'd40, ok);
		// small stamp stuck behind the late one
		next_rand_word(d);
		push_cmd(make_cmd(base + 32'd2, 16'd0, d), base + 32'd40, ok);
		check_val("push accepted", 32'd1, 32'(ok));
		wait_drain();
	endtask

	task automatic test_time_clear();
		logic [31:0] d;
		logic [31:0] ctrl_stamp;
		logic [31:0] last;
		logic        ok;
		test_name = "time_clear";
		ctrl_stamp = current_time + 32'd6;
		push_cmd(make_cmd(ctrl_stamp, `SCHED_CTRL_ADDR, 32'd0), ctrl_stamp, ok);
		check_val("control push accepted", 32'd1, 32'(ok));
		next_rand_word(d);
		push_cmd(make_cmd(32'd3, 16'd2, d), 32'd3, ok);
		check_val("push accepted", 32'd1, 32'(ok));
		last = current_time;
		@(posedge clk);
		while (current_time >= last) begin
			last = current_time;
			@(posedge clk);
		end
		check_val("time restarted below stamp", 32'd1, 32'(current_time < ctrl_stamp));
		check_val("write still pending at clear", 32'd1, exp_q.size());
		wait_drain();
	endtask

	task automatic test_fifo_full();
		logic [31:0] d;
		logic [31:0] stamp;
		logic        ok;
		logic        saw_full;
		int          accepted;
		int          start;
		test_name = "fifo_full";
		accepted = 0;
		saw_full = 1'b0;
		start = fire_count;
		stamp = current_time + 32'd40;
		for (int i = 0; i < DEPTH + 3; i++) begin
			next_rand_word(d);
			push_cmd(make_cmd(stamp + 32'(i), 16'(i % NUM_OUT), d), stamp + 32'(i), ok);
			if (ok)
				accepted++;
			else
				saw_full = 1'b1;
		end
		check_val("full raised", 32'd1, 32'(saw_full));
		wait_drain();
		check_val("strobes vs accepted pushes", accepted, fire_count - start);
	endtask

	initial begin
		cmd_push = 1'b0;
		cmd_in = '0;
		lfsr = 32'hd511_833b;
		for (int i = 0; i < NUM_OUT; i++)
			exp_regs[i] = '0;
		test_reset_idle();
		test_single_write();
		test_ordered_writes();
		test_time_clear();
		test_fifo_full();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
sched_pkg.sv
cmd_fifo.sv
time_base.sv
cmd_scheduler.sv
out_reg_bank.sv
sequencer_top.sv
tb_clock_gen.sv
sequencer_checker.sv
sequencer_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = sequencer_tb
RTL_TOP    = sequencer_top
FILELIST   = src.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# pass only if the run prints the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
